// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -j 0
TOP       = mem_tg_tb
FILELIST  = mem_tg.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = Test OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== include/mem_tg_defs.svh ====
`ifndef MEM_TG_DEFS_SVH
`define MEM_TG_DEFS_SVH

// Word and byte geometry
`define MEM_TG_DATA_WIDTH 32
`define MEM_TG_BE_WIDTH 4
`define MEM_TG_ADDR_WIDTH 6

// Traffic shape
`define MEM_TG_BLOCK_LEN 16
`define MEM_TG_RD_LATENCY 2
`define MEM_TG_COUNT_WIDTH 16

// Nonzero LFSR seeds
`define MEM_TG_DATA_SEED 32'hACE1_2468
`define MEM_TG_BE_SEED 4'h9

`endif

// ==== mem_tg.f ====
+incdir+include
src/mem_tg_pkg.sv
src/mem_tg_pattern_gen.sv
src/mem_tg_sequencer.sv
src/mem_tg_sram.sv
src/mem_tg_status_checker.sv
src/mem_tg_top.sv
tests/mem_tg_tb.sv

// ==== src/mem_tg_pattern_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_tg_pattern_gen
   import mem_tg_pkg::*;
#(
   parameter type payload_t = data_t,
   parameter payload_t seed = '1
) (
   input  wire      clk,
   input  wire      rst,
   input  wire      step,
   input  wire      reload,
   output payload_t value
);

   localparam int WIDTH = $bits(payload_t);

   // Maximal-length taps for the usual widths
   localparam logic [WIDTH-1:0] TAPS =
      (WIDTH == 32) ? WIDTH'(32'h8020_0003) :
      (WIDTH == 16) ? WIDTH'(16'hD008) :
      (WIDTH == 8)  ? WIDTH'(8'hB8) :
      (WIDTH == 4)  ? WIDTH'(4'hC) :
      (WIDTH'(3) << (WIDTH - 2));

   logic [WIDTH-1:0] state;

   // One full word of shifts per step so every payload bit is fresh
   function automatic logic [WIDTH-1:0] advance(input logic [WIDTH-1:0] cur);
      logic [WIDTH-1:0] nxt;
      nxt = cur;
      for (int i = 0; i < WIDTH; i++) begin
         nxt = (nxt << 1) | WIDTH'(^(nxt & TAPS));
      end
      return nxt;
   endfunction

   always_ff @(posedge clk) begin
      if (rst || reload) begin
         state <= seed;
      end else if (step) begin
         state <= advance(state);
      end
   end

   assign value = payload_t'(state);

   // The sequencer never restarts a generator in a cycle that also consumes it
   step_reload_excl: assert property (@(posedge clk) disable iff (rst) !(step && reload));

endmodule

`default_nettype wire

// ==== src/mem_tg_pkg.sv ====
`default_nettype none

`include "mem_tg_defs.svh"

package mem_tg_pkg;

   typedef logic [`MEM_TG_DATA_WIDTH-1:0] data_t;
   typedef logic [`MEM_TG_BE_WIDTH-1:0] be_t;
   typedef logic [`MEM_TG_ADDR_WIDTH-1:0] addr_t;
   typedef logic [`MEM_TG_COUNT_WIDTH-1:0] count_t;

endpackage

`default_nettype wire

// ==== src/mem_tg_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_tg_defs.svh"

module mem_tg_sequencer
   import mem_tg_pkg::*;
(
   input  wire   clk,
   input  wire   rst,
   input  wire   enable,
   input  wire   start,
   input  wire   rd_valid,
   output logic  wr_en,
   output addr_t wr_addr,
   output logic  wr_data_invert,
   output logic  wr_be_masked,
   output logic  wr_step,
   output logic  wr_reload,
   output logic  rd_en,
   output addr_t rd_addr,
   output logic  exp_reload,
   output logic  restart,
   output logic  be_stage,
   output logic  all_issued,
   output logic  in_prog
);

   localparam int LAT = `MEM_TG_RD_LATENCY;
   localparam addr_t LAST_ADDR = addr_t'(`MEM_TG_BLOCK_LEN - 1);

   typedef enum logic [2:0] {
      S_IDLE, S_A_WR, S_A_RD, S_A_DRAIN, S_B_INV, S_B_MASK, S_B_RD, S_B_DRAIN
   } state_t;

   state_t state;
   addr_t addr;
   addr_t addr_next;
   logic [$clog2(LAT+1)-1:0] inflight;
   logic go;
   logic last;
   logic drained;

   assign go = (state == S_IDLE) && enable && start;
   assign last = (addr == LAST_ADDR);
   assign addr_next = last ? '0 : addr + 1'b1;
   assign drained = (inflight == '0);

   ////////////////////////////////////////
   // Issue side
   ////////////////////////////////////////

   assign wr_en = (state == S_A_WR) || (state == S_B_INV) || (state == S_B_MASK);
   assign rd_en = (state == S_A_RD) || (state == S_B_RD);
   assign wr_addr = addr;
   assign rd_addr = addr;
   assign wr_data_invert = (state == S_B_INV);
   assign wr_be_masked = (state == S_B_MASK);

   // Reload just before each write pass starts; the inverted pass hands
   // over on its last write, which then does not step
   assign wr_reload = go || ((state == S_A_DRAIN) && drained) || ((state == S_B_INV) && last);
   assign wr_step = wr_en && !wr_reload;
   assign exp_reload = rd_en && (addr == '0);

   // Reads in flight between issue and return
   always_ff @(posedge clk) begin
      if (rst) begin
         inflight <= '0;
      end else if (rd_en && !rd_valid) begin
         inflight <= inflight + 1'b1;
      end else if (!rd_en && rd_valid) begin
         inflight <= inflight - 1'b1;
      end
   end

   ////////////////////////////////////////
   // Phase FSM
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= S_IDLE;
         addr <= '0;
         restart <= 1'b0;
         be_stage <= 1'b0;
         all_issued <= 1'b0;
         in_prog <= 1'b0;
      end else begin
         restart <= go;
         case (state)
            S_IDLE: begin
               addr <= '0;
               if (go) begin
                  state <= S_A_WR;
                  be_stage <= 1'b0;
                  all_issued <= 1'b0;
                  in_prog <= 1'b1;
               end
            end
            S_A_WR: begin
               addr <= addr_next;
               if (last) state <= S_A_RD;
            end
            S_A_RD: begin
               addr <= addr_next;
               if (last) state <= S_A_DRAIN;
            end
            // Phase B may not start until phase A returns are compared
            S_A_DRAIN: begin
               if (drained) begin
                  state <= S_B_INV;
                  be_stage <= 1'b1;
               end
            end
            S_B_INV: begin
               addr <= addr_next;
               if (last) state <= S_B_MASK;
            end
            S_B_MASK: begin
               addr <= addr_next;
               if (last) state <= S_B_RD;
            end
            S_B_RD: begin
               addr <= addr_next;
               if (last) begin
                  state <= S_B_DRAIN;
                  all_issued <= 1'b1;
               end
            end
            S_B_DRAIN: begin
               if (drained) begin
                  state <= S_IDLE;
                  in_prog <= 1'b0;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // The memory returns every read within its latency
   inflight_bound: assert property (@(posedge clk) disable iff (rst) inflight <= LAT);

endmodule

`default_nettype wire

// ==== src/mem_tg_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_tg_defs.svh"

module mem_tg_sram
   import mem_tg_pkg::*;
(
   input  wire        clk,
   input  wire        rst,
   input  wire        wr_en,
   input  wire addr_t wr_addr,
   input  wire data_t wr_data,
   input  wire be_t   wr_be,
   input  wire        rd_en,
   input  wire addr_t rd_addr,
   input  wire        inject_error,
   output logic       rd_valid,
   output data_t      rd_data
);

   localparam int LAT = `MEM_TG_RD_LATENCY;
   localparam int BYTE_BITS = `MEM_TG_DATA_WIDTH / `MEM_TG_BE_WIDTH;
   localparam int DEPTH = 2 ** `MEM_TG_ADDR_WIDTH;

   data_t mem [DEPTH];
   data_t data_pipe [LAT];
   logic [LAT-1:0] valid_pipe;
   data_t flip_mask;

   // Bit 0 of every byte
   always_comb begin
      flip_mask = '0;
      for (int b = 0; b < `MEM_TG_BE_WIDTH; b++) begin
         flip_mask[b*BYTE_BITS] = 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         for (int b = 0; b < `MEM_TG_BE_WIDTH; b++) begin
            if (wr_be[b]) mem[wr_addr][b*BYTE_BITS +: BYTE_BITS] <= wr_data[b*BYTE_BITS +: BYTE_BITS];
         end
      end
      data_pipe[0] <= mem[rd_addr];
      for (int i = 1; i < LAT; i++) begin
         data_pipe[i] <= data_pipe[i-1];
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_pipe <= '0;
      end else begin
         valid_pipe <= (valid_pipe << 1) | LAT'(rd_en);
      end
   end

   assign rd_valid = valid_pipe[LAT-1];
   assign rd_data = inject_error ? (data_pipe[LAT-1] ^ flip_mask) : data_pipe[LAT-1];

   // Single-port access pattern from the sequencer
   rw_excl: assert property (@(posedge clk) disable iff (rst) !(wr_en && rd_en));

endmodule

`default_nettype wire

// ==== src/mem_tg_status_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_tg_defs.svh"

module mem_tg_status_checker
   import mem_tg_pkg::*;
(
   input  wire        clk,
   input  wire        rst,
   input  wire        enable,
   input  wire        restart,
   input  wire        clear_status,
   input  wire        rd_valid,
   input  wire data_t rd_data,
   input  wire data_t exp_data,
   input  wire be_t   exp_be,
   input  wire addr_t rd_addr_exp,
   input  wire        be_stage,
   input  wire        all_issued,
   input  wire        in_prog,
   output data_t      pnf_per_bit_persist,
   output logic       pass,
   output logic       fail,
   output logic       first_failure_occurred,
   output count_t     failure_count,
   output count_t     total_read_count,
   output data_t      last_read_data,
   output addr_t      first_fail_addr,
   output data_t      first_fail_expected_data,
   output data_t      first_fail_read_data,
   output data_t      first_fail_pnf
);

   localparam int LAT = `MEM_TG_RD_LATENCY;
   localparam int BYTE_BITS = `MEM_TG_DATA_WIDTH / `MEM_TG_BE_WIDTH;

   addr_t addr_pipe [LAT];
   data_t be_full;
   // Stage 1 holds the registered return
   logic rd_valid_r;
   logic be_stage_r;
   data_t rd_data_r;
   data_t exp_data_r;
   data_t be_full_r;
   addr_t addr_r;
   data_t diff;
   data_t pnf_per_bit;
   // Stage 2 feeds the first-failure capture
   logic err_r;
   data_t pnf_r;
   data_t exp_masked_rr;
   data_t rd_masked_rr;
   addr_t addr_rr;
   logic captured;

   always_comb begin
      for (int b = 0; b < `MEM_TG_BE_WIDTH; b++) begin
         be_full[b*BYTE_BITS +: BYTE_BITS] = {BYTE_BITS{exp_be[b]}};
      end
   end

   // Return address lines up with rd_valid
   always_ff @(posedge clk) begin
      addr_pipe[0] <= rd_addr_exp;
      for (int i = 1; i < LAT; i++) begin
         addr_pipe[i] <= addr_pipe[i-1];
      end
      rd_data_r <= rd_data;
      exp_data_r <= exp_data;
      be_full_r <= be_full;
      be_stage_r <= be_stage;
      addr_r <= addr_pipe[LAT-1];
      pnf_r <= pnf_per_bit;
      exp_masked_rr <= exp_data_r & be_full_r;
      rd_masked_rr <= rd_data_r & be_full_r;
      addr_rr <= addr_r;
   end

   ////////////////////////////////////////
   // Per-bit compare
   ////////////////////////////////////////

   assign diff = rd_data_r ^ exp_data_r;

   // Disabled bytes hold the inverted pass data in phase B
   always_comb begin
      if (enable && rd_valid_r) begin
         pnf_per_bit = (be_full_r & ~diff) | (~be_full_r & (be_stage_r ? diff : '1));
      end else begin
         pnf_per_bit = '1;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         rd_valid_r <= 1'b0;
         err_r <= 1'b0;
      end else begin
         rd_valid_r <= rd_valid;
         err_r <= !(&pnf_per_bit);
      end
   end

   always_ff @(posedge clk) begin
      if (rst || clear_status) begin
         pnf_per_bit_persist <= '1;
         total_read_count <= '0;
         last_read_data <= '0;
      end else begin
         pnf_per_bit_persist <= pnf_per_bit_persist & pnf_per_bit;
         if (rd_valid_r) begin
            total_read_count <= total_read_count + 1'b1;
            last_read_data <= rd_data_r & be_full_r;
         end
      end
   end

   ////////////////////////////////////////
   // Failure count and first capture
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst || clear_status) begin
         failure_count <= '0;
         first_failure_occurred <= 1'b0;
         captured <= 1'b0;
         first_fail_addr <= '0;
         first_fail_expected_data <= '0;
         first_fail_read_data <= '0;
         first_fail_pnf <= '1;
      end else begin
         if (restart) first_failure_occurred <= 1'b0;
         if (err_r) begin
            failure_count <= failure_count + 1'b1;
            first_failure_occurred <= 1'b1;
            captured <= 1'b1;
         end
         // Only the first failure since a clear is kept
         if (err_r && !captured) begin
            first_fail_addr <= addr_rr;
            first_fail_expected_data <= exp_masked_rr;
            first_fail_read_data <= rd_masked_rr;
            first_fail_pnf <= pnf_r;
         end
      end
   end

   // err_r covers the last word, whose failure has not reached the flag yet
   always_ff @(posedge clk) begin
      if (rst || restart) begin
         pass <= 1'b0;
         fail <= 1'b0;
      end else begin
         pass <= !first_failure_occurred && !err_r && all_issued && !in_prog;
         fail <= first_failure_occurred && all_issued;
      end
   end

   // Returns only arrive while the sequencer reports a run in progress
   valid_in_run: assert property (@(posedge clk) disable iff (rst) rd_valid |-> in_prog);

endmodule

`default_nettype wire

// ==== src/mem_tg_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_tg_defs.svh"

module mem_tg_top
   import mem_tg_pkg::*;
(
   input  wire    clk,
   input  wire    rst,
   input  wire    enable,
   input  wire    start,
   input  wire    clear_status,
   input  wire    inject_error,
   output data_t  pnf_per_bit_persist,
   output logic   pass,
   output logic   fail,
   output logic   first_failure_occurred,
   output count_t failure_count,
   output count_t total_read_count,
   output data_t  last_read_data,
   output addr_t  first_fail_addr,
   output data_t  first_fail_expected_data,
   output data_t  first_fail_read_data,
   output data_t  first_fail_pnf
);

   logic wr_en, wr_data_invert, wr_be_masked, wr_step, wr_reload;
   logic rd_en, exp_reload, restart, be_stage, all_issued, in_prog;
   logic rd_valid;
   addr_t wr_addr;
   addr_t rd_addr;
   data_t wr_data_pat, exp_data_pat, wr_data, rd_data;
   be_t wr_be_pat, exp_be_pat, wr_be, exp_be;

   mem_tg_sequencer mem_tg_sequencer_i (
      .clk, .rst, .enable, .start, .rd_valid,
      .wr_en, .wr_addr, .wr_data_invert, .wr_be_masked, .wr_step, .wr_reload,
      .rd_en, .rd_addr, .exp_reload, .restart, .be_stage, .all_issued, .in_prog
   );

   ////////////////////////////////////////
   // Write and expected patterns
   ////////////////////////////////////////

   mem_tg_pattern_gen #(.payload_t(data_t), .seed(`MEM_TG_DATA_SEED)) wr_data_gen_i (
      .clk, .rst, .step(wr_step), .reload(wr_reload), .value(wr_data_pat)
   );
   mem_tg_pattern_gen #(.payload_t(be_t), .seed(`MEM_TG_BE_SEED)) wr_be_gen_i (
      .clk, .rst, .step(wr_step), .reload(wr_reload), .value(wr_be_pat)
   );
   mem_tg_pattern_gen #(.payload_t(data_t), .seed(`MEM_TG_DATA_SEED)) exp_data_gen_i (
      .clk, .rst, .step(rd_valid), .reload(exp_reload), .value(exp_data_pat)
   );
   // Byte enables only vary in phase B
   mem_tg_pattern_gen #(.payload_t(be_t), .seed(`MEM_TG_BE_SEED)) exp_be_gen_i (
      .clk, .rst, .step(rd_valid && be_stage), .reload(exp_reload), .value(exp_be_pat)
   );

   assign wr_data = wr_data_invert ? ~wr_data_pat : wr_data_pat;
   assign wr_be = wr_be_masked ? wr_be_pat : '1;
   assign exp_be = be_stage ? exp_be_pat : '1;

   mem_tg_sram mem_tg_sram_i (
      .clk, .rst, .wr_en, .wr_addr, .wr_data, .wr_be,
      .rd_en, .rd_addr, .inject_error, .rd_valid, .rd_data
   );

   mem_tg_status_checker mem_tg_status_checker_i (
      .clk, .rst, .enable, .restart, .clear_status, .rd_valid, .rd_data,
      .exp_data(exp_data_pat), .exp_be, .rd_addr_exp(rd_addr),
      .be_stage, .all_issued, .in_prog,
      .pnf_per_bit_persist, .pass, .fail, .first_failure_occurred,
      .failure_count, .total_read_count, .last_read_data, .first_fail_addr,
      .first_fail_expected_data, .first_fail_read_data, .first_fail_pnf
   );

endmodule

`default_nettype wire

// ==== tests/mem_tg_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_tg_defs.svh"

module mem_tg_tb
   import mem_tg_pkg::*;
;

   localparam int BLOCK_LEN = `MEM_TG_BLOCK_LEN;
   localparam int DATA_WIDTH = `MEM_TG_DATA_WIDTH;
   localparam int BE_WIDTH = `MEM_TG_BE_WIDTH;
   localparam int BYTE_BITS = DATA_WIDTH / BE_WIDTH;
   // Maximal-length polynomials x^32+x^22+x^2+x+1 and x^4+x^3+1
   localparam logic [31:0] DATA_TAPS = 32'h8020_0003;
   localparam logic [31:0] BE_TAPS = 32'h0000_000C;
   localparam int RUN_CYCLES = 120;
   localparam int TIMEOUT_CYCLES = 4 * RUN_CYCLES;

   logic clk;
   logic rst;
   logic enable;
   logic start;
   logic clear_status;
   logic inject_error;
   data_t pnf_per_bit_persist;
   logic pass;
   logic fail;
   logic first_failure_occurred;
   count_t failure_count;
   count_t total_read_count;
   data_t last_read_data;
   addr_t first_fail_addr;
   data_t first_fail_expected_data;
   data_t first_fail_read_data;
   data_t first_fail_pnf;
   logic run_busy;
   int cycles;

   mem_tg_top mem_tg_top_i (
      .clk, .rst, .enable, .start, .clear_status, .inject_error,
      .pnf_per_bit_persist, .pass, .fail, .first_failure_occurred,
      .failure_count, .total_read_count, .last_read_data, .first_fail_addr,
      .first_fail_expected_data, .first_fail_read_data, .first_fail_pnf
   );

   // Run in progress as seen inside the sequencer
   assign run_busy = mem_tg_top_i.mem_tg_sequencer_i.in_prog;

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   ////////////////////////////////////////
   // Failure reporting
   ////////////////////////////////////////

   task automatic stop_with_error(input string why);
      $display("ERROR at %0t ns: %s", $time, why);
      $display("Test FAILED");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      $display("MISMATCH at %0t ns: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
      $display("Test FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else report_mismatch(name, got, exp);
   endtask

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         stop_with_error("timeout, the test did not finish in time");
      end
   end

   ////////////////////////////////////////
   // Reference pattern model
   ////////////////////////////////////////

   // One shift of a Fibonacci LFSR held in the low bits
   function automatic logic [31:0] lfsr_shift(input logic [31:0] state,
                                              input logic [31:0] taps, input int width);
      logic [31:0] mask;
      logic fb;
      mask = (width == 32) ? 32'hFFFF_FFFF : ((32'd1 << width) - 32'd1);
      fb = ^(state & taps);
      return ((state << 1) | 32'(fb)) & mask;
   endfunction

   // Word number index of a sequence with one shift per payload bit
   function automatic logic [31:0] pattern_word(input logic [31:0] seed,
                                                input logic [31:0] taps,
                                                input int width, input int index);
      logic [31:0] s;
      s = seed;
      for (int w = 0; w < index; w++) begin
         for (int b = 0; b < width; b++) begin
            s = lfsr_shift(s, taps, width);
         end
      end
      return s;
   endfunction

   function automatic logic [31:0] byte_mask(input logic [31:0] be);
      logic [31:0] m;
      m = '0;
      for (int b = 0; b < BE_WIDTH; b++) begin
         m[b*BYTE_BITS +: BYTE_BITS] = {BYTE_BITS{be[b]}};
      end
      return m;
   endfunction

   // Bit 0 of every byte
   function automatic logic [31:0] flip_bits();
      logic [31:0] m;
      m = '0;
      for (int b = 0; b < BE_WIDTH; b++) begin
         m[b*BYTE_BITS] = 1'b1;
      end
      return m;
   endfunction

   ////////////////////////////////////////
   // Concurrent checks
   ////////////////////////////////////////

   verdict_excl: assert property (@(posedge clk) disable iff (rst) !(pass && fail))
      else stop_with_error("pass and fail were high at the same time");

   clear_fail_count: assert property (@(posedge clk) disable iff (rst)
      clear_status |=> (failure_count == '0))
      else report_mismatch("failure_count", 32'($sampled(failure_count)), 32'd0);

   clear_read_count: assert property (@(posedge clk) disable iff (rst)
      clear_status |=> (total_read_count == '0))
      else report_mismatch("total_read_count", 32'($sampled(total_read_count)), 32'd0);

   clear_pnf: assert property (@(posedge clk) disable iff (rst)
      clear_status |=> (pnf_per_bit_persist == '1))
      else report_mismatch("pnf_per_bit_persist", $sampled(pnf_per_bit_persist), '1);

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////

   task automatic start_run();
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
      assert (run_busy) else stop_with_error("run did not start after the start pulse");
   endtask

   // Verdict settles two cycles after the run ends
   task automatic wait_run_end();
      while (run_busy) @(negedge clk);
      repeat (2) @(negedge clk);
   endtask

   initial begin
      logic [31:0] final_word;
      logic [31:0] flip;
      logic [31:0] reads;
      rst = 1'b1;
      enable = 1'b0;
      start = 1'b0;
      clear_status = 1'b0;
      inject_error = 1'b0;
      cycles = 0;
      flip = flip_bits();
      // Last read of phase B masked by its byte enables
      final_word = pattern_word(`MEM_TG_DATA_SEED, DATA_TAPS, DATA_WIDTH, BLOCK_LEN - 1) &
                   byte_mask(pattern_word(`MEM_TG_BE_SEED, BE_TAPS, BE_WIDTH, BLOCK_LEN - 1));
      reads = 0;
      repeat (4) @(negedge clk);
      rst = 1'b0;
      enable = 1'b1;

      // Reset state
      check_value("pass", 32'(pass), 32'd0);
      check_value("fail", 32'(fail), 32'd0);
      check_value("first_failure_occurred", 32'(first_failure_occurred), 32'd0);
      check_value("failure_count", 32'(failure_count), 32'd0);
      check_value("total_read_count", 32'(total_read_count), 32'd0);
      check_value("pnf_per_bit_persist", pnf_per_bit_persist, 32'hFFFF_FFFF);

      // Clean run
      start_run();
      wait_run_end();
      reads = reads + 2 * BLOCK_LEN;
      check_value("pass", 32'(pass), 32'd1);
      check_value("fail", 32'(fail), 32'd0);
      check_value("failure_count", 32'(failure_count), 32'd0);
      check_value("total_read_count", 32'(total_read_count), reads);
      check_value("last_read_data", last_read_data, final_word);

      // Every returned word carries the flipped bits
      inject_error = 1'b1;
      start_run();
      wait_run_end();
      inject_error = 1'b0;
      reads = reads + 2 * BLOCK_LEN;
      check_value("pass", 32'(pass), 32'd0);
      check_value("fail", 32'(fail), 32'd1);
      check_value("failure_count", 32'(failure_count), 32'(2 * BLOCK_LEN));
      check_value("total_read_count", 32'(total_read_count), reads);
      check_value("first_fail_addr", 32'(first_fail_addr), 32'd0);
      check_value("first_fail_expected_data", first_fail_expected_data,
                  pattern_word(`MEM_TG_DATA_SEED, DATA_TAPS, DATA_WIDTH, 0));
      check_value("first_fail_xor", first_fail_expected_data ^ first_fail_read_data, flip);
      check_value("first_fail_pnf", first_fail_pnf, ~flip);
      check_value("pnf_per_bit_persist", pnf_per_bit_persist, ~flip);

      // Restart without a clear keeps the counts
      start_run();
      wait_run_end();
      reads = reads + 2 * BLOCK_LEN;
      check_value("pass", 32'(pass), 32'd1);
      check_value("fail", 32'(fail), 32'd0);
      check_value("first_failure_occurred", 32'(first_failure_occurred), 32'd0);
      check_value("failure_count", 32'(failure_count), 32'(2 * BLOCK_LEN));
      check_value("total_read_count", 32'(total_read_count), reads);
      check_value("last_read_data", last_read_data, final_word);
      check_value("pnf_per_bit_persist", pnf_per_bit_persist, ~flip);

      // Clear pulse zeroes the counts and the mask
      clear_status = 1'b1;
      @(negedge clk);
      clear_status = 1'b0;
      check_value("failure_count", 32'(failure_count), 32'd0);
      check_value("total_read_count", 32'(total_read_count), 32'd0);
      check_value("pnf_per_bit_persist", pnf_per_bit_persist, 32'hFFFF_FFFF);
      @(negedge clk);

      $display("Test OK");
      $finish;
   end

endmodule

`default_nettype wire
